//--- dramInitializer.sv
// Writes one header word per bucket after reset, before any ORAM access
// Command and data streams run independently; done holds until the next reset

`timescale 1ns/1ps

`include "oramConsts.svh"

module dramInitializer (
	input logic Clock,
	input logic rstN,

	// Command channel toward DRAM
	output oramPkg::dramCmd_t initCmd,
	output logic initCmdValid,
	input logic initCmdReady,

	// Write-data channel toward DRAM
	output oramPkg::dramWord_t initData,
	output logic initDataValid,
	input logic initDataReady,

	output logic done
);

	// ------------------------------------------------------------
	// Tree bounds
	// ------------------------------------------------------------

	// Wide enough to hold the end count itself
	localparam int bucketCntWidth = $clog2(`ENDOFTREE + 1);

	localparam logic [`DDRAWIDTH-1:0] endOfTreeAddr = `ENDOFTREEADDR;
	localparam logic [bucketCntWidth-1:0] endOfTree = `ENDOFTREE;

	logic [`DDRAWIDTH-1:0] cmdAddr;
	logic [bucketCntWidth-1:0] bucketCnt;

	// ------------------------------------------------------------
	// Address and bucket counters
	// ------------------------------------------------------------

	// One bucket per accepted command
	stepCounter #(
		.width(`DDRAWIDTH),
		.step(`BKTDRWORDS)
	) u_cmdCnt (
		.Clock(Clock),
		.rstN(rstN),
		.enable(initCmdValid & initCmdReady),
		.count(cmdAddr)
	);

	// One header word per accepted beat
	stepCounter #(
		.width(bucketCntWidth),
		.step(1)
	) u_wrtCnt (
		.Clock(Clock),
		.rstN(rstN),
		.enable(initDataValid & initDataReady),
		.count(bucketCnt)
	);

	// ------------------------------------------------------------
	// Channel outputs
	// ------------------------------------------------------------

	// Valid straight after reset, drops at end of tree
	assign initCmdValid = (cmdAddr != endOfTreeAddr);
	assign initDataValid = (bucketCnt != endOfTree);
	assign done = ~initCmdValid & ~initDataValid;

	// Every command is a write
	assign initCmd.address = cmdAddr;
	assign initCmd.command = `DDR3CMDWRITE;

	// Same header for every bucket
	// Empty slots, seed IV, spare bits zero
	always_comb begin
		initData.header.spare = '0;
		initData.header.valid = '0;
		initData.header.iv = `IVINIT;
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------

	// Stalled command holds until accepted
	cmdHoldA: assert property (@(posedge Clock) disable iff (!rstN)
		initCmdValid && !initCmdReady |=> initCmdValid && $stable(initCmd));

	// Once initialized, stays initialized
	doneStickyA: assert property (@(posedge Clock) disable iff (!rstN)
		done |=> done);

endmodule

//--- dramPortMux.sv
// Steers the DRAM channels from the initializer, then from the ORAM controller
// Purely combinational; relies on done never falling before reset

`timescale 1ns/1ps

module dramPortMux (
	input logic Clock,
	input logic rstN,
	input logic done,

	// Initializer side
	input oramPkg::dramCmd_t initCmd,
	input logic initCmdValid,
	output logic initCmdReady,
	input oramPkg::dramWord_t initData,
	input logic initDataValid,
	output logic initDataReady,

	// ORAM controller side
	input oramPkg::dramCmd_t ctrlCmd,
	input logic ctrlCmdValid,
	output logic ctrlCmdReady,
	input oramPkg::dramWord_t ctrlData,
	input logic ctrlDataValid,
	output logic ctrlDataReady,

	// DRAM side
	output oramPkg::dramCmd_t dramCmd,
	output logic dramCmdValid,
	input logic dramCmdReady,
	output oramPkg::dramWord_t dramData,
	output logic dramDataValid,
	input logic dramDataReady
);

	// ------------------------------------------------------------
	// Command channel
	// ------------------------------------------------------------

	// Owner selected by done, no register in path
	assign dramCmd = done ? ctrlCmd : initCmd;
	assign dramCmdValid = done ? ctrlCmdValid : initCmdValid;

	// Ready only reaches the current owner
	assign initCmdReady = ~done & dramCmdReady;
	assign ctrlCmdReady = done & dramCmdReady;

	// ------------------------------------------------------------
	// Write-data channel
	// ------------------------------------------------------------

	assign dramData = done ? ctrlData : initData;
	assign dramDataValid = done ? ctrlDataValid : initDataValid;

	assign initDataReady = ~done & dramDataReady;
	assign ctrlDataReady = done & dramDataReady;

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------

	// Controller traffic only once the whole tree is written
	ctrlAfterInitA: assert property (@(posedge Clock) disable iff (!rstN)
		(ctrlCmdValid && ctrlCmdReady) || (ctrlDataValid && ctrlDataReady)
		|-> done && !initCmdValid && !initDataValid);

	// Initializer stays quiet on both channels while the controller owns them
	initQuietA: assert property (@(posedge Clock) disable iff (!rstN)
		done |-> !initCmdValid && !initDataValid);

endmodule

//--- oramConsts.svh
// Tree geometry and DRAM bus widths shared by RTL and testbench
// Geometry is sized for simulation; the derived counts assume one wasted bucket per subtree

`ifndef ORAM_CONSTS_SVH
`define ORAM_CONSTS_SVH

// ------------------------------------------------------------
// Tree geometry
// ------------------------------------------------------------
`define ORAML 3
`define NUMTOTALST 1
// DRAM words per bucket
`define BKTDRWORDS 4

// ------------------------------------------------------------
// DRAM bus
// ------------------------------------------------------------
`define DDRAWIDTH 16
`define DDRDWIDTH 64
`define DDRCWIDTH 3
`define DDR3CMDWRITE 3'd0
`define DDR3CMDREAD 3'd1

// ------------------------------------------------------------
// Bucket header layout
// ------------------------------------------------------------
`define VALIDBITS 8
`define IVWIDTH 32
`define IVINIT 32'h1357_9bdf
// Upper bits left after valid and IV, driven as zero
`define HDRSPAREBITS (`DDRDWIDTH - `VALIDBITS - `IVWIDTH)

// Buckets in the whole tree, one extra per subtree
`define ENDOFTREE ((1 << (`ORAML + 1)) + `NUMTOTALST)
// First DRAM address past the tree
`define ENDOFTREEADDR (`ENDOFTREE * `BKTDRWORDS)

`endif

//--- oramDramFront.sv
// DRAM start-up front: bucket header init, then pass-through to the ORAM controller
// Read data return is not handled here

`timescale 1ns/1ps

module oramDramFront (
	input logic Clock,
	input logic rstN,

	// ORAM controller channels
	input oramPkg::dramCmd_t ctrlCmd,
	input logic ctrlCmdValid,
	output logic ctrlCmdReady,
	input oramPkg::dramWord_t ctrlData,
	input logic ctrlDataValid,
	output logic ctrlDataReady,

	// DRAM channels
	output oramPkg::dramCmd_t dramCmd,
	output logic dramCmdValid,
	input logic dramCmdReady,
	output oramPkg::dramWord_t dramData,
	output logic dramDataValid,
	input logic dramDataReady,

	output logic initDone
);

	// ------------------------------------------------------------
	// Initializer to mux
	// ------------------------------------------------------------

	oramPkg::dramCmd_t initCmd;
	logic initCmdValid;
	logic initCmdReady;
	oramPkg::dramWord_t initData;
	logic initDataValid;
	logic initDataReady;

	dramInitializer u_init (
		.Clock(Clock),
		.rstN(rstN),
		.initCmd(initCmd),
		.initCmdValid(initCmdValid),
		.initCmdReady(initCmdReady),
		.initData(initData),
		.initDataValid(initDataValid),
		.initDataReady(initDataReady),
		.done(initDone)
	);

	// Done also selects the mux
	dramPortMux u_mux (
		.Clock(Clock),
		.rstN(rstN),
		.done(initDone),
		.initCmd(initCmd),
		.initCmdValid(initCmdValid),
		.initCmdReady(initCmdReady),
		.initData(initData),
		.initDataValid(initDataValid),
		.initDataReady(initDataReady),
		.ctrlCmd(ctrlCmd),
		.ctrlCmdValid(ctrlCmdValid),
		.ctrlCmdReady(ctrlCmdReady),
		.ctrlData(ctrlData),
		.ctrlDataValid(ctrlDataValid),
		.ctrlDataReady(ctrlDataReady),
		.dramCmd(dramCmd),
		.dramCmdValid(dramCmdValid),
		.dramCmdReady(dramCmdReady),
		.dramData(dramData),
		.dramDataValid(dramDataValid),
		.dramDataReady(dramDataReady)
	);

endmodule

//--- oramDramFrontTb.sv
// Testbench for the DRAM start-up front, with the testbench acting as DDR3 side and ORAM controller
// Random readies and controller traffic come from one LFSR with a fixed seed

`timescale 1ns/1ps

`include "oramConsts.svh"

module oramDramFrontTb;

	localparam int clkPeriod = 20;
	localparam int resetCycles = 16;
	localparam int runCycles = 200;
	localparam int doneLimit = 20 * `ENDOFTREE;
	localparam int watchdogNs = 4 * (`ENDOFTREE + runCycles) * clkPeriod;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] lfsrTaps = 32'h8020_0003;

	logic Clock;
	logic rstN;
	oramPkg::dramCmd_t ctrlCmd;
	logic ctrlCmdValid;
	logic ctrlCmdReady;
	oramPkg::dramWord_t ctrlData;
	logic ctrlDataValid;
	logic ctrlDataReady;
	oramPkg::dramCmd_t dramCmd;
	logic dramCmdValid;
	logic dramCmdReady;
	oramPkg::dramWord_t dramData;
	logic dramDataValid;
	logic dramDataReady;
	logic initDone;

	// Model state
	logic [31:0] lfsrState;
	int cyc;
	int initCmdCnt;
	int initDataCnt;
	int lastCmdCyc;
	int lastDataCyc;
	bit doneSeen;
	int ctrlCmdCnt;
	int ctrlDataCnt;
	int checkCount;
	int errCnt [1:5];
	// Controller payloads raised but not yet taken by DRAM
	oramPkg::dramCmd_t cmdQ [$];
	oramPkg::dramWord_t dataQ [$];

	oramDramFront u_dut (
		.Clock(Clock),
		.rstN(rstN),
		.ctrlCmd(ctrlCmd),
		.ctrlCmdValid(ctrlCmdValid),
		.ctrlCmdReady(ctrlCmdReady),
		.ctrlData(ctrlData),
		.ctrlDataValid(ctrlDataValid),
		.ctrlDataReady(ctrlDataReady),
		.dramCmd(dramCmd),
		.dramCmdValid(dramCmdValid),
		.dramCmdReady(dramCmdReady),
		.dramData(dramData),
		.dramDataValid(dramDataValid),
		.dramDataReady(dramDataReady),
		.initDone(initDone)
	);

	// ------------------------------------------------------------
	// Random source
	// ------------------------------------------------------------

	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ lfsrTaps;
		end
		return n;
	endfunction

	// One LFSR step per bit, first bit ends up most significant
	function automatic logic [63:0] takeBits(input int n);
		logic [63:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[62:0], lfsrState[0]};
			lfsrState = nextLfsr(lfsrState);
		end
		return bits;
	endfunction

	// ------------------------------------------------------------
	// Checking
	// ------------------------------------------------------------

	task automatic checkValue(input int testId, input string name,
			input logic [63:0] actual, input logic [63:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errCnt[testId]++;
			$display("ERR %s: got %h expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic reportTest(input int testId, input string title);
		$display("test %0d %s: %s (%0d errors)", testId, title,
			(errCnt[testId] == 0) ? "ok" : "mismatch", errCnt[testId]);
	endtask

	// Reads pre-edge values only, so it sees one settled cycle
	task automatic monitorCycle();
		logic cmdFire;
		logic dataFire;
		int lastFire;
		cmdFire = dramCmdValid && dramCmdReady;
		dataFire = dramDataValid && dramDataReady;
		cyc++;
		// Initializer valid straight out of reset
		if (cyc == 1) begin
			checkValue(1, "dramCmdValid", dramCmdValid, 1'b1);
			checkValue(2, "dramDataValid", dramDataValid, 1'b1);
			checkValue(3, "initDone", initDone, 1'b0);
		end
		if (!initDone) begin
			if (doneSeen) begin
				checkValue(3, "initDone", initDone, 1'b1);
			end
			checkValue(3, "ctrlCmdReady", ctrlCmdReady, 1'b0);
			checkValue(3, "ctrlDataReady", ctrlDataReady, 1'b0);
			// Bucket walk in address order
			if (cmdFire) begin
				checkValue(1, "dramCmd.command", dramCmd.command, `DDR3CMDWRITE);
				checkValue(1, "dramCmd.address", dramCmd.address, initCmdCnt * `BKTDRWORDS);
				initCmdCnt++;
				lastCmdCyc = cyc;
			end
			if (dataFire) begin
				checkValue(2, "dramData.header.iv", dramData.header.iv, `IVINIT);
				checkValue(2, "dramData.header.valid", dramData.header.valid, 0);
				checkValue(2, "dramData.header.spare", dramData.header.spare, 0);
				initDataCnt++;
				lastDataCyc = cyc;
			end
		end else begin
			if (!doneSeen) begin
				doneSeen = 1'b1;
				lastFire = (lastCmdCyc > lastDataCyc) ? lastCmdCyc : lastDataCyc;
				checkValue(1, "initCmdCount", initCmdCnt, `ENDOFTREE);
				checkValue(2, "initDataCount", initDataCnt, `ENDOFTREE);
				checkValue(3, "initDoneCycle", cyc, lastFire + 1);
			end
			// Pass-through, readies mirror the DRAM side
			checkValue(4, "ctrlCmdReady", ctrlCmdReady, dramCmdReady);
			checkValue(4, "dramCmdValid", dramCmdValid, cmdQ.size() != 0);
			if (dramCmdValid && cmdQ.size() != 0) begin
				checkValue(4, "dramCmd", dramCmd, cmdQ[0]);
			end
			if (cmdFire && cmdQ.size() != 0) begin
				void'(cmdQ.pop_front());
				ctrlCmdCnt++;
			end
			checkValue(5, "ctrlDataReady", ctrlDataReady, dramDataReady);
			checkValue(5, "dramDataValid", dramDataValid, dataQ.size() != 0);
			if (dramDataValid && dataQ.size() != 0) begin
				checkValue(5, "dramData", dramData.raw, dataQ[0].raw);
			end
			if (dataFire && dataQ.size() != 0) begin
				void'(dataQ.pop_front());
				ctrlDataCnt++;
			end
		end
	endtask

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------

	task automatic driveInputs();
		oramPkg::dramCmd_t cmd;
		oramPkg::dramWord_t word;
		logic [63:0] bits;
		logic v;
		// Ready high three times in four
		dramCmdReady <= (takeBits(2) != 0);
		dramDataReady <= (takeBits(2) != 0);
		// Pending payload holds until taken
		if (!ctrlCmdValid || ctrlCmdReady) begin
			bits = takeBits(1);
			v = bits[0];
			bits = takeBits(`DDRAWIDTH);
			cmd.address = bits[`DDRAWIDTH-1:0];
			bits = takeBits(`DDRCWIDTH);
			cmd.command = bits[`DDRCWIDTH-1:0];
			ctrlCmdValid <= v;
			ctrlCmd <= cmd;
			if (v) begin
				cmdQ.push_back(cmd);
			end
		end
		if (!ctrlDataValid || ctrlDataReady) begin
			bits = takeBits(1);
			v = bits[0];
			word.raw = takeBits(`DDRDWIDTH);
			ctrlDataValid <= v;
			ctrlData <= word;
			if (v) begin
				dataQ.push_back(word);
			end
		end
	endtask

	initial begin
		Clock = 1'b0;
		forever begin
			#(clkPeriod / 2) Clock = ~Clock;
		end
	end

	// Monitor first, then new inputs for the next cycle
	always @(posedge Clock) begin
		if (rstN) begin
			monitorCycle();
			driveInputs();
		end
	end

	initial begin
		#(watchdogNs);
		$display("watchdog expired after %0d ns, run did not finish", watchdogNs);
		$display("Simulation FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------

	initial begin : mainSeq
		int waited;
		int totalErr;
		int failedTests;
		lfsrState = 32'hb5d5;
		cyc = 0;
		initCmdCnt = 0;
		initDataCnt = 0;
		lastCmdCyc = 0;
		lastDataCyc = 0;
		doneSeen = 1'b0;
		ctrlCmdCnt = 0;
		ctrlDataCnt = 0;
		checkCount = 0;
		for (int i = 1; i <= 5; i++) begin
			errCnt[i] = 0;
		end
		rstN = 1'b0;
		ctrlCmd = '0;
		ctrlCmdValid = 1'b0;
		ctrlData = '0;
		ctrlDataValid = 1'b0;
		dramCmdReady = 1'b0;
		dramDataReady = 1'b0;
		repeat (resetCycles) @(posedge Clock);
		rstN <= 1'b1;
		// Init phase ends when done is seen
		// Falling edge, so the monitor of the rising edge has already run
		waited = 0;
		while (!doneSeen && waited < doneLimit) begin
			@(negedge Clock);
			waited++;
		end
		if (!doneSeen) begin
			errCnt[3]++;
			$display("initDone did not rise within %0d cycles of reset", doneLimit);
		end
		reportTest(1, "init commands");
		reportTest(2, "init header words");
		reportTest(3, "done timing");
		repeat (runCycles) @(negedge Clock);
		if (ctrlCmdCnt == 0) begin
			errCnt[4]++;
			$display("no controller command reached the DRAM side");
		end
		if (ctrlDataCnt == 0) begin
			errCnt[5]++;
			$display("no controller data word reached the DRAM side");
		end
		reportTest(4, "command pass-through");
		reportTest(5, "data pass-through");
		totalErr = 0;
		failedTests = 0;
		for (int i = 1; i <= 5; i++) begin
			totalErr += errCnt[i];
			if (errCnt[i] != 0) begin
				failedTests++;
			end
		end
		$display("tests 5, failing %0d, checks %0d, errors %0d, ctrl cmds %0d, ctrl words %0d",
			failedTests, checkCount, totalErr, ctrlCmdCnt, ctrlDataCnt);
		if (totalErr == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- oramPkg.sv
// Payload types of the DRAM command and write-data channels
// Header view of the write word assumes spare | valid | iv from MSB down

`include "oramConsts.svh"

package oramPkg;

	// ------------------------------------------------------------
	// Command channel payload
	// ------------------------------------------------------------

	// Address in DRAM words, opcode in low bits
	typedef struct packed {
		logic [`DDRAWIDTH-1:0] address;
		logic [`DDRCWIDTH-1:0] command;
	} dramCmd_t;

	// ------------------------------------------------------------
	// Write-data channel payload
	// ------------------------------------------------------------

	// First word of every bucket
	typedef struct packed {
		// Unused upper bits
		logic [`HDRSPAREBITS-1:0] spare;
		// One bit per block slot
		logic [`VALIDBITS-1:0] valid;
		// Encryption seed
		logic [`IVWIDTH-1:0] iv;
	} bucketHeader_t;

	// Same 64 bits, read raw by the bus
	// or as a header by the initializer
	typedef union packed {
		logic [`DDRDWIDTH-1:0] raw;
		bucketHeader_t header;
	} dramWord_t;

endpackage

//--- stepCounter.sv
// Free-running up-counter, wraps silently at 2**width
// Step is truncated to width bits

`timescale 1ns/1ps

module stepCounter #(
	parameter int width = 8,
	parameter int step = 1
) (
	input logic Clock,
	input logic rstN,
	input logic enable,
	output logic [width-1:0] count
);

	// ------------------------------------------------------------
	// Increment
	// ------------------------------------------------------------

	// Step sized once to the counter width
	localparam logic [width-1:0] stepVal = width'(step);

	logic [width-1:0] countNext;

	// Next value only taken when enabled
	assign countNext = count + stepVal;

	// ------------------------------------------------------------
	// State
	// ------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end else if (enable) begin
			count <= countNext;
		end
	end

endmodule

//--- verilog.f
+incdir+.
oramPkg.sv
stepCounter.sv
dramInitializer.sv
dramPortMux.sv
oramDramFront.sv
oramDramFrontTb.sv
